// ==== common/cu_pkg.sv ====
/*
  Compute unit package
  Sizes, memory map offsets and packet formats shared by the
  control block, both requestors and the memory port
*/
package cu_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int ADDR_BITS         = 32;
  localparam int DATA_BITS         = 32;
  localparam int REQUESTOR_COUNT   = 2;
  localparam int REQUESTOR_ID_BITS = 1;

  // FIFO depths and almost-full margin
  localparam int REQUEST_FIFO_DEPTH      = 8;
  localparam int RESPONSE_FIFO_DEPTH     = 8;
  localparam int FIFO_ALMOST_FULL_MARGIN = 2;

  // Done must hold this long before the pulse
  localparam int DONE_HOLD_CYCLES = 16;
  localparam int HOLD_COUNT_BITS  = $clog2(DONE_HOLD_CYCLES + 1);

  // --------------------
  // Memory map
  // --------------------
  // Byte offsets from the descriptor base
  localparam int CONFIG_COUNT_OFFSET = 0;
  localparam int CONFIG_ARRAY_OFFSET = 4;
  localparam int RESULT_OFFSET       = 8;
  localparam int WORD_BYTES          = 4;

  // --------------------
  // Packets
  // --------------------
  typedef enum logic [0:0] {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } mem_cmd_t;

  typedef logic [REQUESTOR_ID_BITS-1:0] requestor_id_t;

  // Requestor ids, also the arbiter slot of each requestor
  localparam requestor_id_t ID_SETUP  = 1'b0;
  localparam requestor_id_t ID_ENGINE = 1'b1;

  typedef struct packed {
    logic [ADDR_BITS-1:0] base_address;
  } descriptor_t;

  typedef struct packed {
    mem_cmd_t             cmd;
    requestor_id_t        id;
    logic [ADDR_BITS-1:0] address;
    // Ignored for reads
    logic [DATA_BITS-1:0] data;
  } mem_request_t;

  typedef struct packed {
    requestor_id_t        id;
    logic [DATA_BITS-1:0] data;
  } mem_response_t;

endpackage

// ==== rtl/memory_port/packet_fifo.sv ====
/*
  Packet FIFO
  Circular buffer for any packed payload, with show-ahead read data,
  an almost-full flag and a setup flag that covers reset
*/
`timescale 1ns/1ps

module packet_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 8
) (
  input  logic     ap_clk,
  input  logic     reset,
  input  payload_t write_data,
  input  logic     write_enable,
  input  logic     read_enable,
  output payload_t read_data,
  output logic     empty,
  output logic     almost_full,
  output logic     fifo_setup
);
  import cu_pkg::*;

  payload_t                     buffer [DEPTH];
  logic [$clog2(DEPTH)-1:0]     write_ptr;
  logic [$clog2(DEPTH)-1:0]     read_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         do_write;
  logic                         do_read;

  // Drop writes into a full buffer and reads from an empty one
  assign do_write = write_enable && (count != DEPTH);
  assign do_read  = read_enable && !empty;

  assign empty       = (count == 0);
  assign almost_full = (count >= DEPTH - FIFO_ALMOST_FULL_MARGIN);
  assign read_data   = buffer[read_ptr];

  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      buffer[write_ptr] <= write_data;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (reset) begin
      write_ptr  <= '0;
      read_ptr   <= '0;
      count      <= '0;
      fifo_setup <= 1'b1;
    end else begin
      fifo_setup <= 1'b0;
      if (do_write) begin
        write_ptr <= (write_ptr == DEPTH - 1) ? '0 : write_ptr + 1'b1;
      end
      if (do_read) begin
        read_ptr <= (read_ptr == DEPTH - 1) ? '0 : read_ptr + 1'b1;
      end
      // Occupancy follows the net change
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/memory_port/request_arbiter.sv ====
/*
  Request arbiter
  Round-robin grant between the requestors into the outgoing
  request FIFO, which drives the memory request port
*/
`timescale 1ns/1ps

module request_arbiter (
  input  logic                                       ap_clk,
  input  logic                                       reset_port,
  input  cu_pkg::mem_request_t                       requests [cu_pkg::REQUESTOR_COUNT],
  input  logic [cu_pkg::REQUESTOR_COUNT-1:0]         request_valids,
  output logic [cu_pkg::REQUESTOR_COUNT-1:0]         grants,
  output cu_pkg::mem_request_t                       mem_request_out,
  output logic                                       mem_request_valid,
  input  logic                                       mem_request_ready,
  output logic                                       empty,
  output logic                                       fifo_setup
);
  import cu_pkg::*;

  requestor_id_t rr_ptr;
  requestor_id_t grant_id;
  logic          found;
  logic          almost_full;

  // Search from the pointer, first valid requestor wins
  always_comb begin
    grants   = '0;
    grant_id = '0;
    found    = 1'b0;
    for (int i = 0; i < REQUESTOR_COUNT; i++) begin
      automatic int idx;
      idx = (int'(rr_ptr) + i) % REQUESTOR_COUNT;
      // No grant once the FIFO nears full
      if (!found && !almost_full && request_valids[idx]) begin
        grants[idx] = 1'b1;
        grant_id    = requestor_id_t'(idx);
        found       = 1'b1;
      end
    end
  end

  // Pointer moves past the last granted requestor
  always_ff @(posedge ap_clk) begin
    if (reset_port) begin
      rr_ptr <= '0;
    end else if (found) begin
      rr_ptr <= (grant_id == REQUESTOR_COUNT - 1) ? '0 : requestor_id_t'(grant_id + 1'b1);
    end
  end

  assign mem_request_valid = !empty;

  packet_fifo #(
    .payload_t (mem_request_t),
    .DEPTH     (REQUEST_FIFO_DEPTH)
  ) request_fifo_i (
    .ap_clk       (ap_clk),
    .reset        (reset_port),
    .write_data   (requests[grant_id]),
    .write_enable (found),
    .read_enable  (mem_request_ready),
    .read_data    (mem_request_out),
    .empty        (empty),
    .almost_full  (almost_full),
    .fifo_setup   (fifo_setup)
  );

endmodule

// ==== rtl/memory_port/response_router.sv ====
/*
  Response router
  Buffers incoming read responses and hands each one to the
  requestor named by its id
*/
`timescale 1ns/1ps

module response_router (
  input  logic                               ap_clk,
  input  logic                               reset_port,
  input  cu_pkg::mem_response_t              mem_response_in,
  input  logic                               mem_response_valid,
  output logic                               mem_response_ready,
  output cu_pkg::mem_response_t              response,
  output logic [cu_pkg::REQUESTOR_COUNT-1:0] response_valids,
  output logic                               empty,
  output logic                               fifo_setup
);
  import cu_pkg::*;

  mem_response_t fifo_data;
  logic          almost_full;

  // Back-pressure the memory before the buffer fills
  assign mem_response_ready = !almost_full;

  packet_fifo #(
    .payload_t (mem_response_t),
    .DEPTH     (RESPONSE_FIFO_DEPTH)
  ) response_fifo_i (
    .ap_clk       (ap_clk),
    .reset        (reset_port),
    .write_data   (mem_response_in),
    .write_enable (mem_response_valid && mem_response_ready),
    .read_enable  (1'b1),
    .read_data    (fifo_data),
    .empty        (empty),
    .almost_full  (almost_full),
    .fifo_setup   (fifo_setup)
  );

  // Requestors always accept, so pop every cycle
  always_ff @(posedge ap_clk) begin
    response <= fifo_data;
  end

  always_ff @(posedge ap_clk) begin
    if (reset_port) begin
      response_valids <= '0;
    end else begin
      response_valids <= '0;
      if (!empty) begin
        response_valids[fifo_data.id] <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/cu_control.sv ====
/*
  Compute unit control
  Per-block reset copies, the descriptor pipeline, setup flag
  combining and the done hold that ends a descriptor with a flush
*/
`timescale 1ns/1ps

module cu_control (
  input  logic                ap_clk,
  input  logic                areset_control,
  input  cu_pkg::descriptor_t descriptor_in,
  input  logic                descriptor_valid,
  input  logic                setup_done,
  input  logic                engine_done,
  // Request FIFO in bit 0, response FIFO in bit 1
  input  logic [1:0]          port_empty,
  input  logic [1:0]          port_fifo_setup,
  output cu_pkg::descriptor_t descriptor_out,
  output logic                descriptor_out_valid,
  output logic                reset_setup,
  output logic                reset_engine,
  output logic                reset_port,
  output logic                flush,
  output logic                fifo_setup_signal,
  output logic                done_out
);
  import cu_pkg::*;

  descriptor_t                descriptor_stage;
  logic                       descriptor_stage_valid;
  logic                       done_condition;
  logic [HOLD_COUNT_BITS-1:0] hold_count;

  // One registered reset copy per block
  always_ff @(posedge ap_clk) begin
    reset_setup  <= areset_control;
    reset_engine <= areset_control;
    reset_port   <= areset_control;
  end

  // --------------------
  // Descriptor pipeline
  // --------------------
  // Payload moves only with its valid, so the last descriptor stays put
  always_ff @(posedge ap_clk) begin
    if (descriptor_valid) begin
      descriptor_stage <= descriptor_in;
    end
    if (descriptor_stage_valid) begin
      descriptor_out <= descriptor_stage;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      descriptor_stage_valid <= 1'b0;
      descriptor_out_valid   <= 1'b0;
      fifo_setup_signal      <= 1'b1;
    end else begin
      descriptor_stage_valid <= descriptor_valid;
      descriptor_out_valid   <= descriptor_stage_valid;
      fifo_setup_signal      <= |port_fifo_setup;
    end
  end

  // --------------------
  // Done hold
  // --------------------
  // Registered condition of both requestors done and both FIFOs drained
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      done_condition <= 1'b0;
      hold_count     <= '0;
      done_out       <= 1'b0;
      flush          <= 1'b0;
    end else begin
      done_condition <= setup_done && engine_done && (&port_empty);
      // Any break restarts the count, saturate after the pulse
      if (!done_condition) begin
        hold_count <= '0;
      end else if (hold_count != DONE_HOLD_CYCLES) begin
        hold_count <= hold_count + 1'b1;
      end
      done_out <= done_condition && (hold_count == DONE_HOLD_CYCLES - 1);
      flush    <= done_condition && (hold_count == DONE_HOLD_CYCLES - 1);
    end
  end

endmodule

// ==== rtl/setup_reader.sv ====
/*
  Setup reader
  Reads the vertex count and the vertex array address for a
  descriptor and passes them on to the vertex engine
*/
`timescale 1ns/1ps

module setup_reader (
  input  logic                                ap_clk,
  input  logic                                reset_setup,
  input  logic                                flush,
  input  cu_pkg::descriptor_t                 descriptor_in,
  input  logic                                descriptor_valid,
  output cu_pkg::mem_request_t                request,
  output logic                                request_valid,
  input  logic                                request_grant,
  input  cu_pkg::mem_response_t               response,
  input  logic                                response_valid,
  output logic [cu_pkg::DATA_BITS-1:0]        vertex_count,
  output logic [cu_pkg::ADDR_BITS-1:0]        array_address,
  output logic                                config_valid,
  output logic                                done
);
  import cu_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_DONE} state_t;

  state_t state;
  logic   second_issued;
  logic   got_count;

  always_ff @(posedge ap_clk) begin
    if (reset_setup || flush) begin
      state         <= S_IDLE;
      request_valid <= 1'b0;
      second_issued <= 1'b0;
      got_count     <= 1'b0;
      config_valid  <= 1'b0;
      done          <= 1'b0;
    end else begin
      config_valid <= 1'b0;
      case (state)
        S_IDLE: if (descriptor_valid) begin
          // Count word first
          request.cmd     <= CMD_READ;
          request.id      <= ID_SETUP;
          request.address <= descriptor_in.base_address + CONFIG_COUNT_OFFSET;
          request.data    <= '0;
          request_valid   <= 1'b1;
          state           <= S_ISSUE;
        end
        S_ISSUE: if (request_grant) begin
          if (!second_issued) begin
            request.address <= descriptor_in.base_address + CONFIG_ARRAY_OFFSET;
            second_issued   <= 1'b1;
          end else begin
            request_valid <= 1'b0;
            state         <= S_WAIT;
          end
        end
        default: ;
      endcase
      // Responses come back in request order
      if (response_valid) begin
        if (!got_count) begin
          vertex_count <= response.data;
          got_count    <= 1'b1;
        end else begin
          array_address <= response.data;
          config_valid  <= 1'b1;
          done          <= 1'b1;
          state         <= S_DONE;
        end
      end
    end
  end

endmodule

// ==== rtl/vertex_engine.sv ====
/*
  Vertex engine
  Streams reads over the vertex array, sums the returned words
  and writes the sum to the result word of the descriptor
*/
`timescale 1ns/1ps

module vertex_engine (
  input  logic                         ap_clk,
  input  logic                         reset_engine,
  input  logic                         flush,
  input  logic [cu_pkg::ADDR_BITS-1:0] result_address,
  input  logic [cu_pkg::DATA_BITS-1:0] vertex_count,
  input  logic [cu_pkg::ADDR_BITS-1:0] array_address,
  input  logic                         config_valid,
  output cu_pkg::mem_request_t         request,
  output logic                         request_valid,
  input  logic                         request_grant,
  input  cu_pkg::mem_response_t        response,
  input  logic                         response_valid,
  output logic                         done
);
  import cu_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE, S_DONE} state_t;

  state_t               state;
  logic [DATA_BITS-1:0] vertex_total;
  logic [DATA_BITS-1:0] issued_count;
  logic [DATA_BITS-1:0] received_count;
  logic [DATA_BITS-1:0] sum;

  always_ff @(posedge ap_clk) begin
    if (reset_engine || flush) begin
      state         <= S_IDLE;
      request_valid <= 1'b0;
      done          <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (config_valid) begin
          vertex_total    <= vertex_count;
          issued_count    <= '0;
          received_count  <= '0;
          sum             <= '0;
          request.id      <= ID_ENGINE;
          request.data    <= '0;
          request_valid   <= 1'b1;
          // Empty array goes straight to the write
          if (vertex_count == 0) begin
            request.cmd     <= CMD_WRITE;
            request.address <= result_address;
            state           <= S_WRITE;
          end else begin
            request.cmd     <= CMD_READ;
            request.address <= array_address;
            state           <= S_READ;
          end
        end
        S_READ: begin
          // Reads keep flowing while responses trickle back
          if (request_grant) begin
            issued_count    <= issued_count + 1'b1;
            request.address <= request.address + WORD_BYTES;
            if (issued_count + 1'b1 == vertex_total) begin
              request_valid <= 1'b0;
            end
          end
          if (response_valid) begin
            sum            <= sum + response.data;
            received_count <= received_count + 1'b1;
          end
          // All words summed, write back
          if (!request_valid && received_count == vertex_total) begin
            request.cmd     <= CMD_WRITE;
            request.address <= result_address;
            request.data    <= sum;
            request_valid   <= 1'b1;
            state           <= S_WRITE;
          end
        end
        S_WRITE: if (request_grant) begin
          request_valid <= 1'b0;
          done          <= 1'b1;
          state         <= S_DONE;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/kernel_cu.sv ====
/*
  Graph kernel compute unit
  Control block, setup reader and vertex engine sharing one
  memory port through a request arbiter and a response router
*/
`timescale 1ns/1ps

module kernel_cu (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  input  cu_pkg::descriptor_t   descriptor_in,
  input  logic                  descriptor_valid,
  output cu_pkg::mem_request_t  mem_request_out,
  output logic                  mem_request_valid,
  input  logic                  mem_request_ready,
  input  cu_pkg::mem_response_t mem_response_in,
  input  logic                  mem_response_valid,
  output logic                  mem_response_ready,
  output logic                  fifo_setup_signal,
  output logic                  done_out
);
  import cu_pkg::*;

  logic                       reset_setup;
  logic                       reset_engine;
  logic                       reset_port;
  logic                       flush;
  descriptor_t                descriptor;
  logic                       descriptor_valid_int;
  mem_request_t               requests [REQUESTOR_COUNT];
  logic [REQUESTOR_COUNT-1:0] request_valids;
  logic [REQUESTOR_COUNT-1:0] grants;
  mem_response_t              response;
  logic [REQUESTOR_COUNT-1:0] response_valids;
  logic [1:0]                 port_empty;
  logic [1:0]                 port_fifo_setup;
  logic                       setup_done;
  logic                       engine_done;
  logic [DATA_BITS-1:0]       vertex_count;
  logic [ADDR_BITS-1:0]       array_address;
  logic                       config_valid;

  cu_control control_i (
    .ap_clk, .areset_control, .descriptor_in, .descriptor_valid,
    .setup_done, .engine_done, .port_empty, .port_fifo_setup,
    .descriptor_out       (descriptor),
    .descriptor_out_valid (descriptor_valid_int),
    .reset_setup, .reset_engine, .reset_port, .flush,
    .fifo_setup_signal, .done_out
  );

  // --------------------
  // Requestors
  // --------------------
  setup_reader setup_i (
    .ap_clk, .reset_setup, .flush,
    .descriptor_in    (descriptor),
    .descriptor_valid (descriptor_valid_int),
    .request          (requests[ID_SETUP]),
    .request_valid    (request_valids[ID_SETUP]),
    .request_grant    (grants[ID_SETUP]),
    .response, .response_valid (response_valids[ID_SETUP]),
    .vertex_count, .array_address, .config_valid,
    .done             (setup_done)
  );

  vertex_engine engine_i (
    .ap_clk, .reset_engine, .flush,
    .result_address (descriptor.base_address + RESULT_OFFSET),
    .vertex_count, .array_address, .config_valid,
    .request        (requests[ID_ENGINE]),
    .request_valid  (request_valids[ID_ENGINE]),
    .request_grant  (grants[ID_ENGINE]),
    .response, .response_valid (response_valids[ID_ENGINE]),
    .done           (engine_done)
  );

  // --------------------
  // Memory port
  // --------------------
  request_arbiter arbiter_i (
    .ap_clk, .reset_port, .requests, .request_valids, .grants,
    .mem_request_out, .mem_request_valid, .mem_request_ready,
    .empty      (port_empty[0]),
    .fifo_setup (port_fifo_setup[0])
  );

  response_router router_i (
    .ap_clk, .reset_port, .mem_response_in, .mem_response_valid,
    .mem_response_ready, .response, .response_valids,
    .empty      (port_empty[1]),
    .fifo_setup (port_fifo_setup[1])
  );

endmodule

// ==== bench/kernel_cu_asserts.sv ====
/*
  Compute unit checker
  Tracks each descriptor from the top-level ports and checks reset
  state, request hold, request order, the result write and done
*/
`timescale 1ns/1ps

module kernel_cu_asserts (
  input logic                  ap_clk,
  input logic                  areset_control,
  input cu_pkg::descriptor_t   descriptor_in,
  input logic                  descriptor_valid,
  input cu_pkg::mem_request_t  mem_request_out,
  input logic                  mem_request_valid,
  input logic                  mem_request_ready,
  input cu_pkg::mem_response_t mem_response_in,
  input logic                  mem_response_valid,
  input logic                  mem_response_ready,
  input logic                  fifo_setup_signal,
  input logic                  done_out
);
  import cu_pkg::*;

  // Failed assertion count
  int unsigned          failures = 0;
  logic                 reset_q;
  logic                 reset_q2;
  logic                 request_fire;
  logic                 response_fire;
  logic                 engine_read;
  logic                 engine_write;
  logic                 write_accepted;
  logic [ADDR_BITS-1:0] base;
  logic [DATA_BITS-1:0] count_word;
  logic [ADDR_BITS-1:0] array_word;
  logic [DATA_BITS-1:0] engine_sum;
  logic [DATA_BITS-1:0] engine_responses;
  logic [DATA_BITS-1:0] setup_responses;
  logic [DATA_BITS-1:0] request_index;

  assign request_fire  = mem_request_valid && mem_request_ready;
  assign response_fire = mem_response_valid && mem_response_ready;
  assign engine_read   = request_fire && mem_request_out.id == ID_ENGINE
                         && mem_request_out.cmd == CMD_READ;
  assign engine_write  = request_fire && mem_request_out.id == ID_ENGINE
                         && mem_request_out.cmd == CMD_WRITE;

  // Two-deep reset history
  always_ff @(posedge ap_clk) begin
    reset_q  <= areset_control;
    reset_q2 <= reset_q;
  end

  // --------------------
  // Descriptor tracking
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control || descriptor_valid) begin
      base             <= descriptor_in.base_address;
      request_index    <= '0;
      setup_responses  <= '0;
      engine_responses <= '0;
      engine_sum       <= '0;
      count_word       <= '0;
      array_word       <= '0;
      write_accepted   <= 1'b0;
    end else begin
      if (request_fire) begin
        request_index <= request_index + 1'b1;
      end
      if (engine_write) begin
        write_accepted <= 1'b1;
      end
      // First setup word is the count, second the array address
      if (response_fire && mem_response_in.id == ID_SETUP) begin
        if (setup_responses == 0) begin
          count_word <= mem_response_in.data;
        end else begin
          array_word <= mem_response_in.data;
        end
        setup_responses <= setup_responses + 1'b1;
      end
      if (response_fire && mem_response_in.id == ID_ENGINE) begin
        engine_sum       <= engine_sum + mem_response_in.data;
        engine_responses <= engine_responses + 1'b1;
      end
    end
  end

  // --------------------
  // Properties
  // --------------------
  // Late reset cycles and the first cycle out of reset
  reset_state_a: assert property (@(posedge ap_clk)
    reset_q2 |-> fifo_setup_signal && !done_out && !mem_request_valid)
    else begin
      $error("FAIL reset state: fifo_setup_signal %h done_out %h mem_request_valid %h",
             fifo_setup_signal, done_out, mem_request_valid);
      failures++;
    end

  // Setup flag clears within three cycles of reset release
  setup_release_a: assert property (@(posedge ap_clk)
    $fell(reset_q2) |=> !fifo_setup_signal)
    else begin
      $error("FAIL fifo_setup_signal %h after reset release, expected 0",
             fifo_setup_signal);
      failures++;
    end

  request_hold_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    mem_request_valid && !mem_request_ready |=> $stable(mem_request_out))
    else begin
      $error("FAIL mem_request_out changed while stalled: was %h now %h",
             $past(mem_request_out), mem_request_out);
      failures++;
    end

  setup_count_read_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    request_fire && request_index == 0 |->
      mem_request_out.cmd == CMD_READ && mem_request_out.id == ID_SETUP
      && mem_request_out.address == base)
    else begin
      $error("FAIL mem_request_out first request %h, base %h", mem_request_out, base);
      failures++;
    end

  setup_array_read_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    request_fire && request_index == 1 |->
      mem_request_out.cmd == CMD_READ && mem_request_out.id == ID_SETUP
      && mem_request_out.address == base + 32'h4)
    else begin
      $error("FAIL mem_request_out second request %h, base %h", mem_request_out, base);
      failures++;
    end

  // Engine reads stay inside the array and come before the write
  engine_read_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    engine_read |-> !write_accepted && mem_request_out.address >= array_word
      && mem_request_out.address < array_word + (count_word << 2))
    else begin
      $error("FAIL mem_request_out.address %h outside array %h count %h",
             mem_request_out.address, array_word, count_word);
      failures++;
    end

  engine_write_address_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    engine_write |-> !write_accepted && mem_request_out.address == base + 32'h8)
    else begin
      $error("FAIL mem_request_out.address %h for result, expected %h",
             mem_request_out.address, base + 32'h8);
      failures++;
    end

  engine_write_data_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    engine_write |-> mem_request_out.data == engine_sum)
    else begin
      $error("FAIL mem_request_out.data %h, expected sum %h",
             mem_request_out.data, engine_sum);
      failures++;
    end

  engine_count_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    engine_write |-> engine_responses == count_word)
    else begin
      $error("FAIL engine responses %h before write, vertex count %h",
             engine_responses, count_word);
      failures++;
    end

  done_pulse_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    done_out |=> !done_out)
    else begin
      $error("FAIL done_out high for more than one cycle: %h", done_out);
      failures++;
    end

  // Result write has to land first
  done_after_write_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    done_out |-> write_accepted)
    else begin
      $error("FAIL done_out %h before result write, write_accepted %h",
             done_out, write_accepted);
      failures++;
    end

endmodule

// ==== bench/tb_kernel_cu.sv ====
/*
  Compute unit testbench
  Sends two descriptors and serves the memory port with random
  response delays and random request back-pressure
*/
`timescale 1ns/1ps

module tb_kernel_cu;
  import cu_pkg::*;

  localparam int CLOCK_PERIOD = 8;
  localparam int DONE_TIMEOUT = 2000;

  logic          ap_clk;
  logic          areset_control;
  descriptor_t   descriptor_in;
  logic          descriptor_valid;
  mem_request_t  mem_request_out;
  logic          mem_request_valid;
  logic          mem_request_ready;
  mem_response_t mem_response_in;
  logic          mem_response_valid;
  logic          mem_response_ready;
  logic          fifo_setup_signal;
  logic          done_out;

  // Memory image of the current descriptor
  logic [ADDR_BITS-1:0] mem_base;
  logic [DATA_BITS-1:0] mem_count;
  logic [ADDR_BITS-1:0] mem_array;
  // Pending read responses and the cycle each one is due
  mem_response_t        response_queue [$];
  int                   due_queue [$];
  int                   cycle;

  kernel_cu dut_i (.*);

  bind kernel_cu kernel_cu_asserts asserts_i (.*);

  initial begin
    ap_clk = 1'b0;
    forever #(CLOCK_PERIOD / 2) ap_clk = ~ap_clk;
  end

  // Config words at base and base + 4, a pattern elsewhere
  function automatic logic [DATA_BITS-1:0] memory_word(input logic [ADDR_BITS-1:0] address);
    if (address == mem_base) begin
      return mem_count;
    end else if (address == mem_base + 32'h4) begin
      return mem_array;
    end
    return address ^ 32'h5a5a0000;
  endfunction

  task automatic send_descriptor(input logic [ADDR_BITS-1:0] base,
                                 input logic [DATA_BITS-1:0] count,
                                 input logic [ADDR_BITS-1:0] array);
    mem_base  = base;
    mem_count = count;
    mem_array = array;
    @(posedge ap_clk);
    descriptor_in.base_address <= base;
    descriptor_valid           <= 1'b1;
    @(posedge ap_clk);
    descriptor_in    <= '0;
    descriptor_valid <= 1'b0;
  endtask

  task automatic wait_done(input string what);
    int waited;
    waited = 0;
    do begin
      @(posedge ap_clk);
      waited++;
    end while (!done_out && waited < DONE_TIMEOUT);
    if (!done_out) begin
      $display("Timed out waiting for done_out after the %s", what);
      $display("Some tests failed");
      $fatal(1, "No done_out within %0d cycles", DONE_TIMEOUT);
    end
  endtask

  // --------------------
  // Memory model
  // --------------------
  initial begin
    mem_response_t entry;
    int            due;
    void'($urandom(32'h12be1934));
    mem_request_ready  = 1'b0;
    mem_response_in    = '0;
    mem_response_valid = 1'b0;
    cycle              = 0;
    forever begin
      @(posedge ap_clk);
      cycle++;
      if (mem_response_valid && mem_response_ready) begin
        void'(response_queue.pop_front());
        void'(due_queue.pop_front());
      end
      // Only reads get a response
      if (mem_request_valid && mem_request_ready && mem_request_out.cmd == CMD_READ) begin
        entry.id   = mem_request_out.id;
        entry.data = memory_word(mem_request_out.address);
        due        = cycle + 1 + int'($urandom % 6);
        // Keep responses in order
        if (due_queue.size() != 0 && due < due_queue[$]) begin
          due = due_queue[$];
        end
        response_queue.push_back(entry);
        due_queue.push_back(due);
      end
      if (response_queue.size() != 0 && due_queue[0] <= cycle) begin
        mem_response_in    <= response_queue[0];
        mem_response_valid <= 1'b1;
      end else begin
        mem_response_valid <= 1'b0;
      end
      // Low about 30% of cycles
      mem_request_ready <= (($urandom % 10) >= 3);
    end
  end

  // Stop at the first checker failure
  initial begin
    forever begin
      @(negedge ap_clk);
      if (dut_i.asserts_i.failures != 0) begin
        $display("Some tests failed");
        $fatal(1, "The bound checker reported a failed assertion");
      end
    end
  end

  initial begin
    areset_control   = 1'b1;
    descriptor_in    = '0;
    descriptor_valid = 1'b0;
    mem_base         = '0;
    mem_count        = '0;
    mem_array        = '0;
    repeat (3) @(posedge ap_clk);
    areset_control <= 1'b0;
    repeat (4) @(posedge ap_clk);
    // Five vertices, then an empty array
    send_descriptor(32'h0000_1000, 32'd5, 32'h0000_2000);
    wait_done("first descriptor");
    repeat (4) @(posedge ap_clk);
    send_descriptor(32'h0000_3000, 32'd0, 32'h0000_4000);
    wait_done("second descriptor");
    repeat (4) @(posedge ap_clk);
    if (dut_i.asserts_i.failures == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Some tests failed");
      $fatal(1, "The bound checker reported a failed assertion");
    end
  end

endmodule

// ==== compile.f ====
common/cu_pkg.sv
rtl/memory_port/packet_fifo.sv
rtl/memory_port/request_arbiter.sv
rtl/memory_port/response_router.sv
rtl/cu_control.sv
rtl/setup_reader.sv
rtl/vertex_engine.sv
rtl/kernel_cu.sv
bench/kernel_cu_asserts.sv
bench/tb_kernel_cu.sv

// ==== Bender.yml ====
package:
  name: kernel_cu

sources:
  - common/cu_pkg.sv
  - rtl/memory_port/packet_fifo.sv
  - rtl/memory_port/request_arbiter.sv
  - rtl/memory_port/response_router.sv
  - rtl/cu_control.sv
  - rtl/setup_reader.sv
  - rtl/vertex_engine.sv
  - rtl/kernel_cu.sv
  - target: test
    files:
      - bench/kernel_cu_asserts.sv
      - bench/tb_kernel_cu.sv
